//--- design/afe_pkg.sv
// widths are fixed by the 16-bit ADC and the 14-bit DAC of the front end
// samples are signed two's complement; converter codes use negative slope
package afe_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // raw converter word as it arrives from the ADC pins
  localparam int unsigned adc_raw_w = 16;

  // low bits of the raw word that carry no data
  localparam int unsigned adc_rsv_w = 2;

  // sample width on both acquisition and generation side
  localparam int unsigned smp_w = 14;

  // one guard bit for the generator plus feedback sum
  localparam int unsigned sum_w = 15;

  //////////////////////////////////////////////////
  // scalar types
  //////////////////////////////////////////////////

  // raw ADC word, reserved bits included
  typedef logic [adc_raw_w-1:0] adc_raw_t;

  // signed sample
  typedef logic signed [smp_w-1:0] smp_t;

  // unsigned negative-slope DAC code
  typedef logic [smp_w-1:0] dac_code_t;

  //////////////////////////////////////////////////
  // rails and constants
  //////////////////////////////////////////////////

  // positive full scale, 0x1FFF
  localparam smp_t smp_max = 14'h1FFF;

  // negative full scale, 0x2000
  localparam smp_t smp_min = 14'h2000;

  // signed zero after negative-slope coding
  localparam dac_code_t dac_zero_code = 14'h1FFF;

  //////////////////////////////////////////////////
  // channel pairs
  //////////////////////////////////////////////////

  // ch_a sits in the upper half of every pair
  typedef struct packed {
    adc_raw_t ch_a;
    adc_raw_t ch_b;
  } raw_pair_t;

  typedef struct packed {
    smp_t ch_a;
    smp_t ch_b;
  } smp_pair_t;

  typedef struct packed {
    dac_code_t ch_a;
    dac_code_t ch_b;
  } code_pair_t;

endpackage

//--- design/adc_capture.sv
// one register stage, no input flops on the raw words
// digital_loop_i is a quasi-static level, switched without a handshake
`timescale 1ns/1ps

module adc_capture (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  // raw converter words, both channels
  input  afe_pkg::raw_pair_t adc_raw_i,
  // saturated mix from the generator side
  input  afe_pkg::smp_pair_t loop_smp_i,
  // select loopback instead of the converter
  input  logic              digital_loop_i,
  // registered two's complement samples
  output afe_pkg::smp_pair_t adc_smp_o
);

  //////////////////////////////////////////////////
  // raw word to sample
  //////////////////////////////////////////////////

  // strip reserved bits, then undo the negative slope
  // msb stays, the remaining bits flip
  function automatic afe_pkg::smp_t adc_conv(input afe_pkg::adc_raw_t raw);
    logic [afe_pkg::smp_w-1:0] fld;
    fld = raw[afe_pkg::adc_raw_w-1:afe_pkg::adc_rsv_w];
    return {fld[afe_pkg::smp_w-1], ~fld[afe_pkg::smp_w-2:0]};
  endfunction

  // converted samples, before the output register
  afe_pkg::smp_pair_t conv_smp;

  // channel a
  assign conv_smp.ch_a = adc_conv(adc_raw_i.ch_a);

  // channel b
  assign conv_smp.ch_b = adc_conv(adc_raw_i.ch_b);

  //////////////////////////////////////////////////
  // output register with loopback select
  //////////////////////////////////////////////////

  // loopback mux sits in front of the flop
  // so both sources see the same single cycle latency
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_smp_o <= '0;
    end else if (digital_loop_i) begin
      // generator mix returned to acquisition
      adc_smp_o <= loop_smp_i;
    end else begin
      // normal acquisition
      adc_smp_o <= conv_smp;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // an unknown select would mix both sources into every later sample
  a_loop_known : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
      !$isunknown(digital_loop_i)
  ) else $error("adc_capture: digital_loop_i unknown");

endmodule

//--- design/dac_mix.sv
// two register stages, mix then code, a new sample pair every cycle
// the sum saturates to the 14-bit rails; no wrap-around reaches the DAC
`timescale 1ns/1ps

module dac_mix (
  input  logic               adc_clk,
  input  logic               arst_n_i,
  // generator samples
  input  afe_pkg::smp_pair_t  gen_smp_i,
  // feedback correction samples
  input  afe_pkg::smp_pair_t  pid_smp_i,
  // registered saturated sum, also the loopback source
  output afe_pkg::smp_pair_t  mix_smp_o,
  // registered negative-slope DAC codes
  output afe_pkg::code_pair_t dac_code_o
);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // sign extend a sample to sum width
  function automatic logic signed [afe_pkg::sum_w-1:0] widen(input afe_pkg::smp_t s);
    return {{(afe_pkg::sum_w - afe_pkg::smp_w){s[afe_pkg::smp_w-1]}}, s};
  endfunction

  // top two bits differ on overflow
  function automatic logic ovf(input logic [afe_pkg::sum_w-1:0] s);
    return s[afe_pkg::sum_w-1] ^ s[afe_pkg::sum_w-2];
  endfunction

  // clamp to the rail picked by the sign bit
  function automatic afe_pkg::smp_t sat(input logic [afe_pkg::sum_w-1:0] s);
    if (ovf(s)) begin
      return s[afe_pkg::sum_w-1] ? afe_pkg::smp_min : afe_pkg::smp_max;
    end
    return s[afe_pkg::smp_w-1:0];
  endfunction

  // signed sample to DAC code, msb kept and the rest flipped
  function automatic afe_pkg::dac_code_t dac_fmt(input afe_pkg::smp_t s);
    return {s[afe_pkg::smp_w-1], ~s[afe_pkg::smp_w-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////

  // unsaturated sums, one guard bit each
  logic signed [afe_pkg::sum_w-1:0] sum_a;
  logic signed [afe_pkg::sum_w-1:0] sum_b;

  // overflow flags, also used by the checks below
  logic ovf_a;
  logic ovf_b;

  // saturated mix, before the first register
  afe_pkg::smp_pair_t sat_smp;

  assign sum_a = widen(gen_smp_i.ch_a) + widen(pid_smp_i.ch_a);
  assign sum_b = widen(gen_smp_i.ch_b) + widen(pid_smp_i.ch_b);

  assign ovf_a = ovf(sum_a);
  assign ovf_b = ovf(sum_b);

  assign sat_smp.ch_a = sat(sum_a);
  assign sat_smp.ch_b = sat(sum_b);

  //////////////////////////////////////////////////
  // mix stage
  //////////////////////////////////////////////////

  // first register, zero after reset
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mix_smp_o <= '0;
    end else begin
      mix_smp_o <= sat_smp;
    end
  end

  //////////////////////////////////////////////////
  // code stage
  //////////////////////////////////////////////////

  // second register, idles at the code of signed zero
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_code_o.ch_a <= afe_pkg::dac_zero_code;
      dac_code_o.ch_b <= afe_pkg::dac_zero_code;
    end else begin
      dac_code_o.ch_a <= dac_fmt(mix_smp_o.ch_a);
      dac_code_o.ch_b <= dac_fmt(mix_smp_o.ch_b);
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // overflowing sum must land on a rail one edge later
  a_sat_rail_a : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
      ovf_a |=> (mix_smp_o.ch_a == afe_pkg::smp_max) ||
                (mix_smp_o.ch_a == afe_pkg::smp_min)
  ) else $error("dac_mix: ch_a overflow not clamped to a rail");

  // same for channel b, checked on its own
  a_sat_rail_b : assert property (
    @(posedge adc_clk) disable iff (!arst_n_i)
      ovf_b |=> (mix_smp_o.ch_b == afe_pkg::smp_max) ||
                (mix_smp_o.ch_b == afe_pkg::smp_min)
  ) else $error("dac_mix: ch_b overflow not clamped to a rail");

endmodule

//--- design/afe_datapath_top.sv
// single adc_clk domain, one asynchronous active-low reset for all flops
// ADC path latency 1 cycle, DAC path 2 cycles, loopback 2 cycles
`timescale 1ns/1ps

module afe_datapath_top (
  input  logic                adc_clk,
  input  logic                arst_n_i,
  //////////////////////////////////////////////////
  // acquisition side
  //////////////////////////////////////////////////
  // raw ADC words
  input  afe_pkg::raw_pair_t   adc_raw_i,
  // converted samples
  output afe_pkg::smp_pair_t   adc_smp_o,
  //////////////////////////////////////////////////
  // generation side
  //////////////////////////////////////////////////
  // generator samples
  input  afe_pkg::smp_pair_t   gen_smp_i,
  // feedback correction samples
  input  afe_pkg::smp_pair_t   pid_smp_i,
  // DAC codes
  output afe_pkg::code_pair_t  dac_code_o,
  // configuration
  input  logic                digital_loop_i
);

  // registered mix, feeds both the DAC coder and the loopback
  afe_pkg::smp_pair_t mix_smp;

  //////////////////////////////////////////////////
  // generator stage
  //////////////////////////////////////////////////

  // sum, saturate, register, code
  dac_mix i_dac_mix (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .gen_smp_i  (gen_smp_i),
    .pid_smp_i  (pid_smp_i),
    .mix_smp_o  (mix_smp),
    .dac_code_o (dac_code_o)
  );

  //////////////////////////////////////////////////
  // acquisition stage
  //////////////////////////////////////////////////

  // loopback taps the mix register, not the DAC code
  // so acquisition sees two's complement directly
  adc_capture i_adc_capture (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_raw_i      (adc_raw_i),
    .loop_smp_i     (mix_smp),
    .digital_loop_i (digital_loop_i),
    .adc_smp_o      (adc_smp_o)
  );

endmodule

//--- test/afe_ref.svh
// reference model of the sample path, built from the conversion rules
// included inside the testbench module, afe_pkg must be compiled first
`ifndef AFE_REF_SVH
`define AFE_REF_SVH

//////////////////////////////////////////////////
// run constants
//////////////////////////////////////////////////

localparam int clk_period_ns   = 10;
localparam int rst_cycles      = 5;
localparam int adc_cycles      = 200;
localparam int mix_cycles      = 200;
localparam int sat_dir_cycles  = 6;
localparam int sat_rnd_cycles  = 100;
localparam int loop_cycles     = 100;
localparam int loop_off_cycles = 20;
// idle cycles after each test so the pipeline empties
localparam int drain_cycles    = 3;

// every driven cycle, drains included
localparam int total_cycles = adc_cycles + mix_cycles + sat_dir_cycles + sat_rnd_cycles
                            + loop_cycles + loop_off_cycles + 4 * drain_cycles + 1;
localparam int timeout_ns = 2 * total_cycles * clk_period_ns + rst_cycles * clk_period_ns;

localparam logic [31:0] tb_seed = 32'h6787_547e;

//////////////////////////////////////////////////
// reference functions
//////////////////////////////////////////////////

// bits 15..2 of the raw word, sign kept, lower 13 bits flipped
function automatic afe_pkg::smp_t ref_adc(input afe_pkg::adc_raw_t raw);
  logic [13:0] fld;
  fld = raw[15:2];
  return fld ^ 14'h1FFF;
endfunction

// full-precision sum, clamped to the 14-bit rails
function automatic afe_pkg::smp_t ref_sat(input afe_pkg::smp_t g, input afe_pkg::smp_t p);
  int s;
  s = int'(g) + int'(p);
  if (s > 8191) return 14'h1FFF;
  if (s < -8192) return 14'h2000;
  return s[13:0];
endfunction

// negative-slope code, sign kept and the rest flipped
function automatic afe_pkg::dac_code_t ref_dac(input afe_pkg::smp_t s);
  return s ^ 14'h1FFF;
endfunction

`endif

//--- test/afe_tb.sv
// inputs change and outputs are checked on the falling edge
// expected values come from the model in afe_ref.svh with one queue per output path
`timescale 1ns/1ps

module afe_tb;

  `include "afe_ref.svh"

  logic                adc_clk;
  logic                arst_n_i;
  afe_pkg::raw_pair_t  adc_raw_i;
  afe_pkg::smp_pair_t  gen_smp_i;
  afe_pkg::smp_pair_t  pid_smp_i;
  logic                digital_loop_i;
  afe_pkg::smp_pair_t  adc_smp_o;
  afe_pkg::code_pair_t dac_code_o;

  // expected outputs are pushed on the rising edge and popped on the falling edge
  afe_pkg::smp_pair_t  exp_adc_q[$];
  afe_pkg::code_pair_t exp_code_q[$];
  // model of the mix register
  afe_pkg::smp_pair_t  model_mix;
  afe_pkg::smp_pair_t  exp_adc;
  afe_pkg::code_pair_t exp_code;

  int err_cnt = 0;
  int check_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int err_mark = 0;
  bit dir;

  afe_datapath_top UUT (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_raw_i      (adc_raw_i),
    .adc_smp_o      (adc_smp_o),
    .gen_smp_i      (gen_smp_i),
    .pid_smp_i      (pid_smp_i),
    .dac_code_o     (dac_code_o),
    .digital_loop_i (digital_loop_i)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(clk_period_ns / 2) adc_clk = ~adc_clk;
  end

  // watchdog
  initial begin
    #(timeout_ns);
    $display("timeout: run did not finish within %0d ns", timeout_ns);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_val(input string name, input logic [13:0] exp_v,
                           input logic [13:0] act_v);
    check_cnt++;
    assert (act_v === exp_v) else begin
      $display("MISMATCH %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////
  // model and compare
  ////////////////////////////////////////////////////

  // inputs are stable on the rising edge
  always @(posedge adc_clk) begin
    if (!arst_n_i) begin
      model_mix = '0;
      exp_adc_q.delete();
      exp_code_q.delete();
    end else begin
      if (digital_loop_i) begin
        exp_adc = model_mix;
      end else begin
        exp_adc.ch_a = ref_adc(adc_raw_i.ch_a);
        exp_adc.ch_b = ref_adc(adc_raw_i.ch_b);
      end
      exp_code.ch_a = ref_dac(model_mix.ch_a);
      exp_code.ch_b = ref_dac(model_mix.ch_b);
      exp_adc_q.push_back(exp_adc);
      exp_code_q.push_back(exp_code);
      // mix register takes the new sum at this edge
      model_mix.ch_a = ref_sat(gen_smp_i.ch_a, pid_smp_i.ch_a);
      model_mix.ch_b = ref_sat(gen_smp_i.ch_b, pid_smp_i.ch_b);
    end
  end

  // outputs are stable half a cycle after the edge
  always @(negedge adc_clk) begin
    if (exp_adc_q.size() != 0) begin
      exp_adc = exp_adc_q.pop_front();
      exp_code = exp_code_q.pop_front();
      check_val("adc_smp_o.ch_a", exp_adc.ch_a, adc_smp_o.ch_a);
      check_val("adc_smp_o.ch_b", exp_adc.ch_b, adc_smp_o.ch_b);
      check_val("dac_code_o.ch_a", exp_code.ch_a, dac_code_o.ch_a);
      check_val("dac_code_o.ch_b", exp_code.ch_b, dac_code_o.ch_b);
    end
  end

  ////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////

  task automatic start_test();
    err_mark = err_cnt;
  endtask

  // waits a rising edge so the last falling-edge check is counted
  task automatic end_test(input string name);
    @(posedge adc_clk);
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: fail, %0d errors", name, err_cnt - err_mark);
    end
  endtask

  task automatic drain();
    repeat (drain_cycles) @(negedge adc_clk);
  endtask

  task automatic drive_mix(input int ga, input int pa, input int gb, input int pb);
    @(negedge adc_clk);
    gen_smp_i.ch_a = afe_pkg::smp_t'(ga);
    pid_smp_i.ch_a = afe_pkg::smp_t'(pa);
    gen_smp_i.ch_b = afe_pkg::smp_t'(gb);
    pid_smp_i.ch_b = afe_pkg::smp_t'(pb);
  endtask

  // within a quarter of full scale
  function automatic int rnd_qtr();
    return int'($urandom_range(4095)) - 2048;
  endfunction

  // up to 63 steps inside a rail
  function automatic int near_rail(input bit pos);
    int r;
    r = $urandom_range(63);
    return pos ? 8191 - r : -8192 + r;
  endfunction

  // small push toward the same rail
  function automatic int push_off(input bit pos);
    int r;
    r = $urandom_range(127);
    return pos ? r : -r;
  endfunction

  ////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////

  initial begin
    void'($urandom(tb_seed));
    arst_n_i = 1'b0;
    digital_loop_i = 1'b0;
    adc_raw_i = '0;
    gen_smp_i = '0;
    pid_smp_i = '0;
    repeat (rst_cycles) @(negedge adc_clk);
    arst_n_i = 1'b1;

    start_test();
    check_val("adc_smp_o.ch_a", 14'h0000, adc_smp_o.ch_a);
    check_val("adc_smp_o.ch_b", 14'h0000, adc_smp_o.ch_b);
    check_val("dac_code_o.ch_a", afe_pkg::dac_zero_code, dac_code_o.ch_a);
    check_val("dac_code_o.ch_b", afe_pkg::dac_zero_code, dac_code_o.ch_b);
    end_test("reset values");

    start_test();
    repeat (adc_cycles) begin
      @(negedge adc_clk);
      adc_raw_i.ch_a = afe_pkg::adc_raw_t'($urandom);
      adc_raw_i.ch_b = afe_pkg::adc_raw_t'($urandom);
    end
    drain();
    end_test("adc conversion");

    start_test();
    repeat (mix_cycles) drive_mix(rnd_qtr(), rnd_qtr(), rnd_qtr(), rnd_qtr());
    drain();
    end_test("unsaturated mixing");

    start_test();
    drive_mix(8191, 8191, -8192, -8192);
    drive_mix(8191, 1, -8192, -1);
    drive_mix(8191, -8192, -8192, 8191);
    drive_mix(4096, 4096, -4096, -4097);
    drive_mix(8191, 0, -8192, 0);
    drive_mix(-1, -8192, 1, 8191);
    // channels pushed toward opposite rails
    repeat (sat_rnd_cycles) begin
      dir = ($urandom_range(1) != 0);
      drive_mix(near_rail(dir), push_off(dir), near_rail(!dir), push_off(!dir));
    end
    drain();
    end_test("saturation");

    start_test();
    @(negedge adc_clk);
    digital_loop_i = 1'b1;
    repeat (loop_cycles) begin
      drive_mix(rnd_qtr() * 3, rnd_qtr() * 3, rnd_qtr() * 3, rnd_qtr() * 3);
      adc_raw_i.ch_a = afe_pkg::adc_raw_t'($urandom);
      adc_raw_i.ch_b = afe_pkg::adc_raw_t'($urandom);
    end
    // back to the converter path
    digital_loop_i = 1'b0;
    repeat (loop_off_cycles) begin
      drive_mix(rnd_qtr(), rnd_qtr(), rnd_qtr(), rnd_qtr());
      adc_raw_i.ch_a = afe_pkg::adc_raw_t'($urandom);
      adc_raw_i.ch_b = afe_pkg::adc_raw_t'($urandom);
    end
    drain();
    end_test("digital loopback");

    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+test
design/afe_pkg.sv
design/adc_capture.sv
design/dac_mix.sv
design/afe_datapath_top.sv
test/afe_tb.sv
